// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f datapath.f --top-module datapath_tb -Mdir obj_dir
	./obj_dir/Vdatapath_tb | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: datapath.f
+incdir+test
hdl/cpu_types_pkg.sv
hdl/pipeline_pkg.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/datapath.sv
test/datapath_tb.sv

// File: hdl/cpu_types_pkg.sv
// rv32 subset only; HALT uses the custom-0 major opcode and carries no operands
`default_nettype none

package cpu_types_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] regbits_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    // custom-0 slot
    HALT   = 7'b0001011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/datapath.sv
// memories must answer combinationally in the same cycle; HALT freezes the core until reset
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  wire                  CLK,
  input  wire                  nRST,
  input  cpu_types_pkg::word_t i_imem_data,
  output cpu_types_pkg::word_t o_imem_addr,
  output cpu_types_pkg::word_t o_dmem_addr,
  output cpu_types_pkg::word_t o_dmem_wdata,
  input  cpu_types_pkg::word_t i_dmem_rdata,
  output logic                 o_dmem_wen,
  output logic                 o_dmem_ren,
  output logic                 o_halt
);

  cpu_types_pkg::word_t pc, pc_next;

  pipeline_pkg::if_id_t  if_id;
  pipeline_pkg::id_ex_t  id_ex;
  pipeline_pkg::ex_mem_t ex_mem;
  pipeline_pkg::mem_wb_t mem_wb;

  pipeline_pkg::ctrl_t     dec_ctrl;
  cpu_types_pkg::regbits_t dec_rs1, dec_rs2, dec_rd;
  cpu_types_pkg::word_t    dec_imm, rdat1, rdat2;

  cpu_types_pkg::word_t ex_result, ex_store_data, target, wb_data;
  logic redirect, stall, flush;
  logic halt_q, freeze;

  // fetch
  assign o_imem_addr = pc;
  assign pc_next = redirect ? target : pc + 32'd4;

  // decode
  decode_unit u_decode (
    .i_instr (if_id.instr),
    .o_ctrl  (dec_ctrl),
    .o_rs1   (dec_rs1),
    .o_rs2   (dec_rs2),
    .o_rd    (dec_rd),
    .o_imm   (dec_imm)
  );

  register_file u_regs (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_rsel1 (dec_rs1),
    .i_rsel2 (dec_rs2),
    .i_wsel  (mem_wb.rd),
    .i_wen   (mem_wb.ctrl.reg_wr),
    .i_wdat  (wb_data),
    .o_rdat1 (rdat1),
    .o_rdat2 (rdat2)
  );

  // execute
  execute_unit u_execute (
    .i_id_ex      (id_ex),
    .i_ex_mem     (ex_mem),
    .i_mem_wb     (mem_wb),
    .i_wb_data    (wb_data),
    .o_result     (ex_result),
    .o_store_data (ex_store_data),
    .o_redirect   (redirect),
    .o_target     (target)
  );

  hazard_unit u_hazard (
    .i_ex_mem_rd (id_ex.rd),
    .i_ex_load   (id_ex.ctrl.mem_rd),
    .i_dec_rs1   (dec_rs1),
    .i_dec_rs2   (dec_rs2),
    .i_redirect  (redirect),
    .o_stall     (stall),
    .o_flush     (flush)
  );

  // memory
  assign o_dmem_addr  = ex_mem.result;
  assign o_dmem_wdata = ex_mem.store_data;
  assign o_dmem_wen   = ex_mem.ctrl.mem_wr;
  assign o_dmem_ren   = ex_mem.ctrl.mem_rd;

  // writeback select
  assign wb_data = mem_wb.ctrl.mem_rd ? mem_wb.load_data : mem_wb.result;

  // halt in memory stage stops everything younger than it
  assign freeze = ex_mem.ctrl.halt;
  assign o_halt = halt_q;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      halt_q <= 1'b0;
    else if (ex_mem.ctrl.halt)
      halt_q <= 1'b1;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      pc <= cpu_types_pkg::RESET_PC;
    else if (!freeze && !stall)
      pc <= pc_next;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      if_id  <= '{pc: cpu_types_pkg::RESET_PC, instr: cpu_types_pkg::NOP_INSTR};
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else
    begin
      if (!freeze)
      begin
        if (flush)
          if_id <= '{pc: cpu_types_pkg::RESET_PC, instr: cpu_types_pkg::NOP_INSTR};
        else if (!stall)
          if_id <= '{pc: pc, instr: i_imem_data};

        // bubble behind a load or a taken branch
        if (flush || stall)
          id_ex <= '0;
        else
          id_ex <= '{ctrl: dec_ctrl, pc: if_id.pc, rs1: dec_rs1, rs2: dec_rs2,
                     rd: dec_rd, rdat1: rdat1, rdat2: rdat2, imm: dec_imm};

        ex_mem <= '{ctrl: id_ex.ctrl, rd: id_ex.rd, result: ex_result,
                    store_data: ex_store_data};
      end

      // older instructions drain, then halt sits here
      mem_wb <= '{ctrl: ex_mem.ctrl, rd: ex_mem.rd, result: ex_mem.result,
                  load_data: i_dmem_rdata};
    end
  end

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
// word loads/stores only; unsupported encodings decode to a bubble with zero register indices
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  cpu_types_pkg::word_t    i_instr,
  output pipeline_pkg::ctrl_t     o_ctrl,
  output cpu_types_pkg::regbits_t o_rs1,
  output cpu_types_pkg::regbits_t o_rs2,
  output cpu_types_pkg::regbits_t o_rd,
  output cpu_types_pkg::word_t    o_imm
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  cpu_types_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'h000};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  always_comb
  begin
    o_ctrl = '0;
    o_rs1  = '0;
    o_rs2  = '0;
    o_rd   = '0;
    o_imm  = '0;
    case (cpu_types_pkg::opcode_t'(i_instr[6:0]))
      cpu_types_pkg::OP:
      begin
        o_ctrl.reg_wr = 1'b1;
        o_rs1 = i_instr[19:15];
        o_rs2 = i_instr[24:20];
        o_rd  = i_instr[11:7];
        case (funct3)
          3'b000:  o_ctrl.alu_op = funct7[5] ? cpu_types_pkg::ALU_SUB : cpu_types_pkg::ALU_ADD;
          3'b111:  o_ctrl.alu_op = cpu_types_pkg::ALU_AND;
          3'b110:  o_ctrl.alu_op = cpu_types_pkg::ALU_OR;
          3'b100:  o_ctrl.alu_op = cpu_types_pkg::ALU_XOR;
          3'b010:  o_ctrl.alu_op = cpu_types_pkg::ALU_SLT;
          default:
          begin
            o_ctrl = '0;
            o_rs1  = '0;
            o_rs2  = '0;
            o_rd   = '0;
          end
        endcase
      end
      cpu_types_pkg::OP_IMM:
      begin
        // addi only
        if (funct3 == 3'b000)
        begin
          o_ctrl.reg_wr      = 1'b1;
          o_ctrl.alu_src_imm = 1'b1;
          o_rs1 = i_instr[19:15];
          o_rd  = i_instr[11:7];
          o_imm = imm_i;
        end
      end
      cpu_types_pkg::LUI:
      begin
        o_ctrl.reg_wr = 1'b1;
        o_ctrl.is_lui = 1'b1;
        o_rd  = i_instr[11:7];
        o_imm = imm_u;
      end
      cpu_types_pkg::LOAD:
      begin
        if (funct3 == 3'b010)
        begin
          o_ctrl.reg_wr      = 1'b1;
          o_ctrl.mem_rd      = 1'b1;
          o_ctrl.alu_src_imm = 1'b1;
          o_rs1 = i_instr[19:15];
          o_rd  = i_instr[11:7];
          o_imm = imm_i;
        end
      end
      cpu_types_pkg::STORE:
      begin
        if (funct3 == 3'b010)
        begin
          o_ctrl.mem_wr      = 1'b1;
          o_ctrl.alu_src_imm = 1'b1;
          o_rs1 = i_instr[19:15];
          o_rs2 = i_instr[24:20];
          o_imm = imm_s;
        end
      end
      cpu_types_pkg::BRANCH:
      begin
        // beq and bne
        if (funct3[2:1] == 2'b00)
        begin
          o_ctrl.is_branch = 1'b1;
          o_ctrl.branch_ne = funct3[0];
          o_rs1 = i_instr[19:15];
          o_rs2 = i_instr[24:20];
          o_imm = imm_b;
        end
      end
      cpu_types_pkg::JAL:
      begin
        o_ctrl.reg_wr = 1'b1;
        o_ctrl.is_jal = 1'b1;
        o_rd  = i_instr[11:7];
        o_imm = imm_j;
      end
      cpu_types_pkg::HALT: o_ctrl.halt = 1'b1;
      default: o_ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
// a load result is never forwarded from the memory stage; the hazard unit stalls that case
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  pipeline_pkg::id_ex_t  i_id_ex,
  input  pipeline_pkg::ex_mem_t i_ex_mem,
  input  pipeline_pkg::mem_wb_t i_mem_wb,
  input  cpu_types_pkg::word_t  i_wb_data,
  output cpu_types_pkg::word_t  o_result,
  output cpu_types_pkg::word_t  o_store_data,
  output logic                  o_redirect,
  output cpu_types_pkg::word_t  o_target
);

  cpu_types_pkg::word_t op_a, fwd_b, op_b, alu_out;
  logic mem_fwd_a, mem_fwd_b, wb_fwd_a, wb_fwd_b;
  logic equal, taken;

  // memory stage is the younger producer, so it wins
  assign mem_fwd_a = i_ex_mem.ctrl.reg_wr && i_ex_mem.rd != '0 && i_ex_mem.rd == i_id_ex.rs1;
  assign mem_fwd_b = i_ex_mem.ctrl.reg_wr && i_ex_mem.rd != '0 && i_ex_mem.rd == i_id_ex.rs2;
  assign wb_fwd_a  = i_mem_wb.ctrl.reg_wr && i_mem_wb.rd != '0 && i_mem_wb.rd == i_id_ex.rs1;
  assign wb_fwd_b  = i_mem_wb.ctrl.reg_wr && i_mem_wb.rd != '0 && i_mem_wb.rd == i_id_ex.rs2;

  always_comb
  begin
    if (mem_fwd_a)
      op_a = i_ex_mem.result;
    else if (wb_fwd_a)
      op_a = i_wb_data;
    else
      op_a = i_id_ex.rdat1;

    if (mem_fwd_b)
      fwd_b = i_ex_mem.result;
    else if (wb_fwd_b)
      fwd_b = i_wb_data;
    else
      fwd_b = i_id_ex.rdat2;
  end

  assign op_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : fwd_b;

  always_comb
  begin
    case (i_id_ex.ctrl.alu_op)
      cpu_types_pkg::ALU_ADD: alu_out = op_a + op_b;
      cpu_types_pkg::ALU_SUB: alu_out = op_a - op_b;
      cpu_types_pkg::ALU_AND: alu_out = op_a & op_b;
      cpu_types_pkg::ALU_OR:  alu_out = op_a | op_b;
      cpu_types_pkg::ALU_XOR: alu_out = op_a ^ op_b;
      cpu_types_pkg::ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      default:                alu_out = op_a + op_b;
    endcase
  end

  // link address for jal, upper immediate for lui
  assign o_result = i_id_ex.ctrl.is_jal ? i_id_ex.pc + 32'd4 :
                    i_id_ex.ctrl.is_lui ? i_id_ex.imm : alu_out;

  assign o_store_data = fwd_b;

  // branch compare on forwarded operands
  assign equal = (op_a == fwd_b);
  assign taken = i_id_ex.ctrl.is_branch && (i_id_ex.ctrl.branch_ne ? !equal : equal);

  assign o_redirect = taken || i_id_ex.ctrl.is_jal;
  assign o_target   = i_id_ex.pc + i_id_ex.imm;

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
// one-cycle load-use stall only; a redirect always wins over a stall
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_types_pkg::regbits_t i_ex_mem_rd,
  input  logic                    i_ex_load,
  input  cpu_types_pkg::regbits_t i_dec_rs1,
  input  cpu_types_pkg::regbits_t i_dec_rs2,
  input  logic                    i_redirect,
  output logic                    o_stall,
  output logic                    o_flush
);

  logic load_use;

  // load in execute feeding the instruction in decode
  assign load_use = i_ex_load && i_ex_mem_rd != '0 &&
                    (i_ex_mem_rd == i_dec_rs1 || i_ex_mem_rd == i_dec_rs2);

  assign o_flush = i_redirect;
  assign o_stall = load_use && !i_redirect;

endmodule

`default_nettype wire

// File: hdl/pipeline_pkg.sv
// every control bit is active high, so an all-zero struct is a bubble in any stage
`default_nettype none

package pipeline_pkg;

  // alu_op of zero means add
  typedef struct packed {
    logic                   reg_wr;
    logic                   mem_rd;
    logic                   mem_wr;
    logic                   alu_src_imm;
    logic                   is_branch;
    logic                   branch_ne;
    logic                   is_jal;
    logic                   is_lui;
    logic                   halt;
    cpu_types_pkg::alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    cpu_types_pkg::word_t pc;
    cpu_types_pkg::word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    cpu_types_pkg::word_t    pc;
    cpu_types_pkg::regbits_t rs1;
    cpu_types_pkg::regbits_t rs2;
    cpu_types_pkg::regbits_t rd;
    cpu_types_pkg::word_t    rdat1;
    cpu_types_pkg::word_t    rdat2;
    cpu_types_pkg::word_t    imm;
  } id_ex_t;

  // result is the alu value, the load address, LUI value or the link address
  typedef struct packed {
    ctrl_t                   ctrl;
    cpu_types_pkg::regbits_t rd;
    cpu_types_pkg::word_t    result;
    cpu_types_pkg::word_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    cpu_types_pkg::regbits_t rd;
    cpu_types_pkg::word_t    result;
    cpu_types_pkg::word_t    load_data;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: hdl/register_file.sv
// x0 is hardwired to zero; a write in the same cycle is visible on both read ports
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                     CLK,
  input  wire                     nRST,
  input  cpu_types_pkg::regbits_t i_rsel1,
  input  cpu_types_pkg::regbits_t i_rsel2,
  input  cpu_types_pkg::regbits_t i_wsel,
  input  logic                    i_wen,
  input  cpu_types_pkg::word_t    i_wdat,
  output cpu_types_pkg::word_t    o_rdat1,
  output cpu_types_pkg::word_t    o_rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (i_wen && i_wsel != '0)
      regs[i_wsel] <= i_wdat;
  end

  // writeback bypass
  assign o_rdat1 = (i_rsel1 == '0) ? '0 :
                   (i_wen && i_wsel == i_rsel1) ? i_wdat : regs[i_rsel1];
  assign o_rdat2 = (i_rsel2 == '0) ? '0 :
                   (i_wen && i_wsel == i_rsel2) ? i_wdat : regs[i_rsel2];

endmodule

`default_nettype wire

// File: test/program_table.svh
// tests 0..4 only; up to 24 instructions and 8 expected stores each, test 0 takes two random immediates
typedef struct {
  string       name;
  int          n_instr;
  logic [31:0] prog [24];
  int          n_st;
  logic [31:0] st_addr [8];
  logic [31:0] st_data [8];
} test_t;

localparam int NUM_TESTS = 5;

test_t tests [NUM_TESTS];

task automatic put_instr(input int t, input logic [31:0] w);
  tests[t].prog[tests[t].n_instr] = w;
  tests[t].n_instr++;
endtask

task automatic expect_store(input int t, input logic [31:0] addr, input logic [31:0] data);
  tests[t].st_addr[tests[t].n_st] = addr;
  tests[t].st_data[tests[t].n_st] = data;
  tests[t].n_st++;
endtask

// a and b are the sign-extended random immediates for test 0
task automatic build_table(input int a, input int b);
  int r3, r4, r5, r6, r7, r8;
  for (int t = 0; t < NUM_TESTS; t++)
  begin
    tests[t].n_instr = 0;
    tests[t].n_st = 0;
  end
  r3 = a + b;
  r4 = r3 - a;
  r5 = r4 & r3;
  r6 = r5 | a;
  r7 = r6 ^ b;
  r8 = (r7 < r6) ? 1 : 0;

  tests[0].name = "alu_forwarding";
  put_instr(0, itype(a, 0, 0, 1, OPC_IMM));
  put_instr(0, itype(b, 0, 0, 2, OPC_IMM));
  put_instr(0, rtype(0, 2, 1, 0, 3));
  put_instr(0, rtype(32'h20, 1, 3, 0, 4));
  put_instr(0, rtype(0, 3, 4, 7, 5));
  put_instr(0, rtype(0, 1, 5, 6, 6));
  put_instr(0, rtype(0, 2, 6, 4, 7));
  put_instr(0, rtype(0, 6, 7, 2, 8));
  for (int r = 3; r <= 8; r++)
    put_instr(0, stype(32'h100 + (r - 3) * 4, r, 0));
  put_instr(0, HALT_INSTR);
  expect_store(0, 32'h100, r3);
  expect_store(0, 32'h104, r4);
  expect_store(0, 32'h108, r5);
  expect_store(0, 32'h10c, r6);
  expect_store(0, 32'h110, r7);
  expect_store(0, 32'h114, r8);

  tests[1].name = "load_use";
  put_instr(1, itype(77, 0, 0, 1, OPC_IMM));
  put_instr(1, itype(5, 0, 0, 4, OPC_IMM));
  put_instr(1, stype(32'h200, 1, 0));
  put_instr(1, itype(32'h200, 0, 2, 2, OPC_LOAD));
  put_instr(1, rtype(0, 4, 2, 0, 3));
  put_instr(1, stype(32'h204, 3, 0));
  put_instr(1, HALT_INSTR);
  expect_store(1, 32'h200, 77);
  expect_store(1, 32'h204, 82);

  // beq at 8 jumps to 20 over two marker stores
  tests[2].name = "branches";
  put_instr(2, itype(3, 0, 0, 1, OPC_IMM));
  put_instr(2, itype(3, 0, 0, 2, OPC_IMM));
  put_instr(2, btype(12, 2, 1, 0));
  put_instr(2, stype(32'h300, 1, 0));
  put_instr(2, stype(32'h304, 2, 0));
  put_instr(2, btype(8, 2, 1, 1));
  put_instr(2, itype(9, 0, 0, 3, OPC_IMM));
  put_instr(2, stype(32'h308, 3, 0));
  put_instr(2, HALT_INSTR);
  expect_store(2, 32'h308, 9);

  tests[3].name = "jal_lui";
  put_instr(3, utype(32'h12345, 1));
  put_instr(3, jtype(12, 2));
  put_instr(3, stype(32'h0c8, 1, 0));
  put_instr(3, stype(32'h0cc, 1, 0));
  put_instr(3, stype(32'h0c0, 2, 0));
  put_instr(3, stype(32'h0c4, 1, 0));
  put_instr(3, HALT_INSTR);
  expect_store(3, 32'h0c0, 32'h8);
  expect_store(3, 32'h0c4, 32'h1234_5000);

  tests[4].name = "halt_x0";
  put_instr(4, itype(55, 0, 0, 0, OPC_IMM));
  put_instr(4, itype(12, 0, 0, 1, OPC_IMM));
  put_instr(4, rtype(0, 1, 1, 0, 0));
  put_instr(4, stype(32'h080, 0, 0));
  put_instr(4, HALT_INSTR);
  put_instr(4, stype(32'h084, 1, 0));
  put_instr(4, stype(32'h088, 1, 0));
  expect_store(4, 32'h080, 0);
endtask

// File: test/datapath_tb.sv
// 64 instruction and 256 data words; spare instruction slots hold HALT tagged with the slot index
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;

  localparam logic [6:0] OPC_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [31:0] HALT_INSTR = 32'h0000_000b;
  localparam int HOLD_CYCLES = 4;

  logic CLK = 1'b0;
  logic nRST;
  logic [31:0] imem [64];
  logic [31:0] dmem [256];
  logic [31:0] imem_addr, dmem_addr, dmem_wdata, imem_data, dmem_rdata;
  logic dmem_wen, dmem_ren, halt;
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic [15:0] lfsr;
  logic running;
  int cycles = 0;
  int limit, passes, fails;

  function automatic logic [31:0] rtype(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(input int off, input int rs2, input int rs1,
                                        input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] utype(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] jtype(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  `include "program_table.svh"

  // galois form with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_imm(output logic [11:0] v);
    v = '0;
    for (int i = 0; i < 12; i++)
    begin
      v = {v[10:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  datapath u_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .i_imem_data  (imem_data),
    .o_imem_addr  (imem_addr),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_ren   (dmem_ren),
    .o_halt       (halt)
  );

  always #5 CLK = ~CLK;

  assign imem_data  = imem[imem_addr[7:2]];
  // read data only while a load is in the memory stage
  assign dmem_rdata = dmem_ren ? dmem[dmem_addr[9:2]] : 32'hbad0_0bad;

  // data memory write and store trace
  always @(posedge CLK)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 256; i++)
        dmem[i] <= 32'hd000_0000 | (i << 2);
      log_addr.delete();
      log_data.delete();
    end
    else if (dmem_wen)
    begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
    end
  end

  always @(posedge CLK)
  begin
    if (running)
      cycles <= cycles + 1;
    if (running && cycles >= limit)
    begin
      $display("timeout: halt never came within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic run_test(input int t);
    int errs;
    errs = 0;
    @(posedge CLK);
    nRST <= 1'b0;
    repeat (2) @(posedge CLK);
    if (dmem_wen || dmem_ren || halt)
    begin
      $display("%s: memory strobes or halt were not low in reset", tests[t].name);
      errs++;
    end
    for (int i = 0; i < 64; i++)
      imem[i] = (i < tests[t].n_instr) ? tests[t].prog[i] : (HALT_INSTR | (i << 7));
    nRST <= 1'b1;
    running <= 1'b1;
    @(posedge CLK);
    while (!halt)
      @(posedge CLK);
    running <= 1'b0;
    repeat (HOLD_CYCLES)
    begin
      @(posedge CLK);
      if (!halt)
      begin
        $display("%s: halt dropped after it was raised", tests[t].name);
        errs++;
      end
    end
    if (log_addr.size() != tests[t].n_st)
    begin
      $display("%s: expected %0d stores but saw %0d", tests[t].name, tests[t].n_st,
               log_addr.size());
      errs++;
    end
    for (int i = 0; i < tests[t].n_st && i < log_addr.size(); i++)
    begin
      if (log_addr[i] !== tests[t].st_addr[i] || log_data[i] !== tests[t].st_data[i])
      begin
        $display("ERR %0t: %s store %0d got [%h]=%h, expected [%h]=%h", $time,
                 tests[t].name, i, log_addr[i], log_data[i], tests[t].st_addr[i],
                 tests[t].st_data[i]);
        errs++;
      end
    end
    if (errs == 0)
    begin
      $display("pass  %s", tests[t].name);
      passes++;
    end
    else
    begin
      $display("fail  %s (%0d errors)", tests[t].name, errs);
      fails++;
    end
  endtask

  initial
  begin
    logic [11:0] ia, ib;
    nRST <= 1'b0;
    running <= 1'b0;
    for (int i = 0; i < 64; i++)
      imem[i] = HALT_INSTR | (i << 7);
    passes = 0;
    fails = 0;
    lfsr = 16'd63;
    draw_imm(ia);
    draw_imm(ib);
    build_table(int'($signed(ia)), int'($signed(ib)));
    limit = 0;
    for (int t = 0; t < NUM_TESTS; t++)
      limit += 4 * tests[t].n_instr + 20;
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("passed %0d, failed %0d", passes, fails);
    if (fails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
